/* source/vmask_params.svh */
`ifndef VMASK_PARAMS_SVH
`define VMASK_PARAMS_SVH

// Mask register width in bits
`define VLEN 128
// Scalar and element width
`define XLEN 32
// viota and vid elements per micro-op
`define ELEMS_PER_UOP 4
// Micro-ops per viota or vid instruction
`define NUM_UOPS 32
`define UOP_W 5

`endif

/* source/vmask_pkg.sv */
package vmask_pkg;

    // Special mask operations handled by the unit
    typedef enum logic [2:0] {
        VMSK_NONE = 3'd0,
        VMSK_CNT  = 3'd1,
        VMSK_FST  = 3'd2,
        VMSK_SBF  = 3'd3,
        VMSK_SIF  = 3'd4,
        VMSK_SOF  = 3'd5,
        VMSK_ITA  = 3'd6,
        VMSK_IDX  = 3'd7
    } vmaskop_t;

    // Calculator states
    // vcpop and vfirst share the chunk walk
    // The latched op picks the datapath
    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        CHUNK_1    = 4'd1,
        CHUNK_2    = 4'd2,
        CHUNK_DONE = 4'd3,
        SET_BF     = 4'd4,
        SET_IF     = 4'd5,
        SET_OF     = 4'd6
    } calc_state_t;

endpackage

/* source/vmask_cfg_regs.sv */
`timescale 1ns/1ps
`include "vmask_params.svh"

module vmask_cfg_regs (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              cfg_we,
    input  logic [`XLEN-1:0]  cfg_vl,
    input  logic              cfg_mask_en,
    input  logic              busy,
    output logic [`XLEN-1:0]  vl,
    output logic              mask_en
);

    logic [`XLEN-1:0] vl_q;
    logic             mask_en_q;
    logic [`XLEN-1:0] vl_sat;
    logic             wr_ok;

    // Lengths past the register width behave as a full register
    assign vl_sat = (cfg_vl > `XLEN'(`VLEN)) ? `XLEN'(`VLEN) : cfg_vl;

    // Running instruction must see constant settings
    assign wr_ok = cfg_we && !busy;

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            vl_q      <= '0;
            mask_en_q <= 1'b0;
        end else if (wr_ok) begin
            vl_q      <= vl_sat;
            mask_en_q <= cfg_mask_en;
        end
    end

    assign vl      = vl_q;
    assign mask_en = mask_en_q;

endmodule

/* source/vmask_seq.sv */
`timescale 1ns/1ps
`include "vmask_params.svh"

module vmask_seq import vmask_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              flush,
    input  logic              stall,
    input  logic              start,
    input  vmaskop_t          op,
    input  logic              calc_busy,
    output vmaskop_t          cur_op,
    output logic              go,
    output logic [`UOP_W-1:0] uop_num,
    output logic              final_uop,
    output logic              busy
);

    vmaskop_t          op_q;
    logic              run_q;
    logic [`UOP_W-1:0] uop_q;
    logic              take;
    logic              vec_op;

    // New instruction only when nothing is in flight
    assign take = start && !stall && !flush && !run_q && !calc_busy;

    // Start cycle already works on the incoming op
    assign cur_op = take ? op : op_q;
    assign vec_op = (cur_op == VMSK_ITA) || (cur_op == VMSK_IDX);

    // One go for a chunk walk, one per unstalled micro-op for viota and vid
    assign go = take || (run_q && !stall && !flush);

    assign uop_num   = take ? '0 : uop_q;
    assign final_uop = vec_op && (uop_num == `UOP_W'(`NUM_UOPS - 1));

    assign busy = run_q || calc_busy;

    always_ff @(posedge CLK) begin
        if (!nRST || flush) begin
            op_q  <= VMSK_NONE;
            run_q <= 1'b0;
            uop_q <= '0;
        end else begin
            if (take) begin
                op_q <= op;
            end
            if (go && vec_op) begin
                // Stay running until the last micro-op goes out
                run_q <= !final_uop;
                uop_q <= final_uop ? '0 : uop_num + 1'b1;
            end
        end
    end

endmodule

/* source/vmask_calc.sv */
`timescale 1ns/1ps
`include "vmask_params.svh"

module vmask_calc import vmask_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              flush,
    input  logic              go,
    input  vmaskop_t          cur_op,
    input  logic [`UOP_W-1:0] uop_num,
    input  logic              final_uop,
    input  logic [`XLEN-1:0]  vl,
    input  logic              mask_en,
    input  logic [`VLEN-1:0]  mask_src,
    input  logic [`VLEN-1:0]  mask_dest,
    input  logic [`VLEN-1:0]  v0_mask,
    output logic              calc_busy,
    output logic              scalar_load,
    output logic [`XLEN-1:0]  scalar_out,
    output logic              vector_load,
    output logic [`VLEN-1:0]  vector_out
);

    calc_state_t state, next_state;

    // Chunk walk accumulator for the count or the first index
    logic [`XLEN-1:0] acc_q, acc_next;
    // Running prefix sum across viota and vid micro-ops
    logic [`XLEN-1:0] sum_q, sum_next;

    logic [`VLEN-1:0] src_masked;
    logic [1:0]       chunk_idx;
    logic [`XLEN-1:0] chunk_bits;
    logic [5:0]       chunk_pop;
    logic [4:0]       enc_idx;
    logic             enc_hit;
    logic [`XLEN-1:0] cnt_next;
    logic [`XLEN-1:0] first_next;
    logic [`XLEN-1:0] walk_val;
    logic             walk_op;
    logic             vec_op;
    logic             set_state;

    logic                      first_none;
    logic [$clog2(`VLEN)-1:0]  first_idx;
    logic [`VLEN-1:0]          vms_raw;
    logic [`VLEN-1:0]          vms_out;

    logic [`UOP_W+1:0]         iota_base;
    logic [`ELEMS_PER_UOP-1:0] iota_bits;
    logic [`VLEN-1:0]          iota_out;
    logic [`XLEN-1:0]          iota_carry;

    assign walk_op   = cur_op inside {VMSK_CNT, VMSK_FST, VMSK_SBF, VMSK_SIF, VMSK_SOF};
    assign vec_op    = cur_op inside {VMSK_ITA, VMSK_IDX};
    assign set_state = state inside {SET_BF, SET_IF, SET_OF};

    // Active source bits within the body and under v0 when masking is on
    always_comb begin
        for (int i = 0; i < `VLEN; i++) begin
            src_masked[i] = mask_src[i] && (32'(i) < vl) && (!mask_en || v0_mask[i]);
        end
    end

    // One 32-bit chunk per state with chunk 0 in the start cycle
    always_comb begin
        case (state)
            CHUNK_1:    chunk_idx = 2'd1;
            CHUNK_2:    chunk_idx = 2'd2;
            CHUNK_DONE: chunk_idx = 2'd3;
            default:    chunk_idx = 2'd0;
        endcase
        chunk_bits = src_masked[{chunk_idx, 5'b0} +: `XLEN];

        chunk_pop = '0;
        for (int i = 0; i < `XLEN; i++) begin
            chunk_pop = chunk_pop + 6'(chunk_bits[i]);
        end

        // Scan downwards so that the lowest set bit wins
        enc_hit = |chunk_bits;
        enc_idx = '0;
        for (int i = `XLEN - 1; i >= 0; i--) begin
            if (chunk_bits[i]) begin
                enc_idx = 5'(i);
            end
        end
    end

    assign cnt_next = ((state == IDLE) ? '0 : acc_q) + `XLEN'(chunk_pop);

    always_comb begin
        if (state != IDLE && acc_q != '1) begin
            first_next = acc_q;
        end else if (enc_hit) begin
            first_next = {{(`XLEN - 7){1'b0}}, chunk_idx, enc_idx};
        end else begin
            first_next = '1;
        end
    end

    assign walk_val = (cur_op == VMSK_CNT) ? cnt_next : first_next;

    always_comb begin
        next_state = state;
        acc_next   = acc_q;
        sum_next   = sum_q;
        case (state)
            IDLE: begin
                if (go && walk_op) begin
                    next_state = CHUNK_1;
                    acc_next   = walk_val;
                end else if (go && vec_op) begin
                    sum_next = final_uop ? '0 : iota_carry;
                end
            end
            CHUNK_1: begin
                next_state = CHUNK_2;
                acc_next   = walk_val;
            end
            CHUNK_2: begin
                next_state = CHUNK_DONE;
                acc_next   = walk_val;
            end
            CHUNK_DONE: begin
                acc_next = walk_val;
                case (cur_op)
                    VMSK_SBF: next_state = SET_BF;
                    VMSK_SIF: next_state = SET_IF;
                    VMSK_SOF: next_state = SET_OF;
                    default: begin
                        next_state = IDLE;
                        acc_next   = '0;
                    end
                endcase
            end
            default: begin
                next_state = IDLE;
                acc_next   = '0;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!nRST || flush) begin
            state <= IDLE;
            acc_q <= '0;
            sum_q <= '0;
        end else begin
            state <= next_state;
            acc_q <= acc_next;
            sum_q <= sum_next;
        end
    end

    // vmsbf, vmsif, vmsof from the first index found by the walk
    always_comb begin
        first_none = (acc_q == '1);
        first_idx  = acc_q[$clog2(`VLEN)-1:0];
        case (state)
            SET_BF:  vms_raw = first_none ? '1 : (`VLEN'(1) << first_idx) - 1'b1;
            SET_IF:  vms_raw = first_none ? '1 : ((`VLEN'(1) << first_idx) << 1) - 1'b1;
            SET_OF:  vms_raw = first_none ? '0 : `VLEN'(1) << first_idx;
            default: vms_raw = '0;
        endcase
        // Tail and masked-off bits keep the destination value
        for (int i = 0; i < `VLEN; i++) begin
            if (32'(i) >= vl || (mask_en && !v0_mask[i])) begin
                vms_out[i] = mask_dest[i];
            end else begin
                vms_out[i] = vms_raw[i];
            end
        end
    end

    // Prefix sum over this micro-op's mask bits
    // vid counts every bit as one
    always_comb begin
        iota_base = {uop_num, 2'b00};
        if (cur_op == VMSK_IDX) begin
            iota_bits = '1;
        end else begin
            iota_bits = src_masked[iota_base +: `ELEMS_PER_UOP];
        end
        iota_out[`XLEN-1:0] = sum_q;
        for (int k = 1; k < `ELEMS_PER_UOP; k++) begin
            iota_out[k*`XLEN +: `XLEN] = iota_out[(k-1)*`XLEN +: `XLEN] +
                                         `XLEN'(iota_bits[k-1]);
        end
        iota_carry = iota_out[(`ELEMS_PER_UOP-1)*`XLEN +: `XLEN] +
                     `XLEN'(iota_bits[`ELEMS_PER_UOP-1]);
    end

    assign calc_busy   = (state != IDLE);
    assign scalar_load = (state == CHUNK_DONE) && (cur_op inside {VMSK_CNT, VMSK_FST});
    assign scalar_out  = walk_val;
    assign vector_load = set_state || ((state == IDLE) && go && vec_op);
    assign vector_out  = set_state ? vms_out : iota_out;

endmodule

/* source/vmask_result_latch.sv */
`timescale 1ns/1ps

module vmask_result_latch #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     flush,
    input  logic     load,
    input  payload_t data_in,
    output logic     valid,
    output payload_t data_out
);

    logic     valid_q;
    payload_t data_q;

    always_ff @(posedge CLK) begin
        if (!nRST || flush) begin
            valid_q <= 1'b0;
        end else begin
            // One-cycle pulse per load
            valid_q <= load;
        end
    end

    // Payload stays put until the next load
    always_ff @(posedge CLK) begin
        if (load) begin
            data_q <= data_in;
        end
    end

    assign valid    = valid_q;
    assign data_out = data_q;

endmodule

/* source/vmask_unit.sv */
`timescale 1ns/1ps
`include "vmask_params.svh"

module vmask_unit import vmask_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             cfg_we,
    input  logic [`XLEN-1:0] cfg_vl,
    input  logic             cfg_mask_en,
    input  logic             start,
    input  vmaskop_t         op,
    input  logic [`VLEN-1:0] mask_src,
    input  logic [`VLEN-1:0] mask_dest,
    input  logic [`VLEN-1:0] v0_mask,
    input  logic             stall,
    input  logic             flush,
    output logic             busy,
    output logic             scalar_valid,
    output logic [`XLEN-1:0] scalar_result,
    output logic             vector_valid,
    output logic [`VLEN-1:0] vector_result
);

    logic [`XLEN-1:0]  vl;
    logic              mask_en;
    vmaskop_t          cur_op;
    logic              go;
    logic [`UOP_W-1:0] uop_num;
    logic              final_uop;
    logic              calc_busy;
    logic              scalar_load;
    logic [`XLEN-1:0]  scalar_out;
    logic              vector_load;
    logic [`VLEN-1:0]  vector_out;

    vmask_cfg_regs u_cfg (
        .CLK(CLK), .nRST(nRST), .cfg_we(cfg_we), .cfg_vl(cfg_vl),
        .cfg_mask_en(cfg_mask_en), .busy(busy), .vl(vl), .mask_en(mask_en)
    );

    vmask_seq u_seq (
        .CLK(CLK), .nRST(nRST), .flush(flush), .stall(stall), .start(start),
        .op(op), .calc_busy(calc_busy), .cur_op(cur_op), .go(go),
        .uop_num(uop_num), .final_uop(final_uop), .busy(busy)
    );

    vmask_calc u_calc (
        .CLK(CLK), .nRST(nRST), .flush(flush), .go(go), .cur_op(cur_op),
        .uop_num(uop_num), .final_uop(final_uop), .vl(vl), .mask_en(mask_en),
        .mask_src(mask_src), .mask_dest(mask_dest), .v0_mask(v0_mask),
        .calc_busy(calc_busy), .scalar_load(scalar_load), .scalar_out(scalar_out),
        .vector_load(vector_load), .vector_out(vector_out)
    );

    // vcpop and vfirst results
    vmask_result_latch #(.payload_t(logic [`XLEN-1:0])) u_scalar (
        .CLK(CLK), .nRST(nRST), .flush(flush), .load(scalar_load),
        .data_in(scalar_out), .valid(scalar_valid), .data_out(scalar_result)
    );

    // vms*, viota and vid results
    vmask_result_latch #(.payload_t(logic [`VLEN-1:0])) u_vector (
        .CLK(CLK), .nRST(nRST), .flush(flush), .load(vector_load),
        .data_in(vector_out), .valid(vector_valid), .data_out(vector_result)
    );

endmodule

/* verif/vmask_unit_props.sv */
`timescale 1ns/1ps

module vmask_unit_props (
    input logic CLK,
    input logic nRST,
    input logic flush,
    input logic busy,
    input logic scalar_valid,
    input logic vector_valid
);

    // Scalar and vector results never share a cycle
    valid_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(scalar_valid && vector_valid))
        else $error("scalar_valid and vector_valid were high in the same cycle");

    flush_idles: assert property (@(posedge CLK) disable iff (!nRST)
        flush |=> !busy)
        else $error("busy was still high in the cycle after flush");

    reset_quiet: assert property (@(posedge CLK)
        !nRST |=> (!scalar_valid && !vector_valid))
        else $error("a valid output was high after reset");

endmodule

bind vmask_unit vmask_unit_props u_props (
    .CLK(CLK), .nRST(nRST), .flush(flush), .busy(busy),
    .scalar_valid(scalar_valid), .vector_valid(vector_valid)
);

/* verif/vmask_unit_tb.sv */
`timescale 1ns/1ps
`include "vmask_params.svh"

module vmask_unit_tb import vmask_pkg::*; ();

    localparam int MAX_VECS   = 64;
    localparam int WALK_LIMIT = 40;
    localparam int VEC_LIMIT  = 400;
    localparam int IDLE_LIMIT = 40;

    logic             CLK;
    logic             nRST;
    logic             cfg_we;
    logic [`XLEN-1:0] cfg_vl;
    logic             cfg_mask_en;
    logic             start;
    vmaskop_t         op;
    logic [`VLEN-1:0] mask_src;
    logic [`VLEN-1:0] mask_dest;
    logic [`VLEN-1:0] v0_mask;
    logic             stall;
    logic             flush;
    logic             busy;
    logic             scalar_valid;
    logic [`XLEN-1:0] scalar_result;
    logic             vector_valid;
    logic [`VLEN-1:0] vector_result;

    // One entry per line of the vector file
    vmaskop_t         op_list   [MAX_VECS];
    logic [`XLEN-1:0] vl_list   [MAX_VECS];
    logic             en_list   [MAX_VECS];
    logic [`VLEN-1:0] src_list  [MAX_VECS];
    logic [`VLEN-1:0] dest_list [MAX_VECS];
    logic [`VLEN-1:0] v0_list   [MAX_VECS];
    int               num_vecs;

    int checks;
    int mismatches;
    int timeouts;
    int setup_errors;

    vmask_unit DUT (
        .CLK(CLK), .nRST(nRST), .cfg_we(cfg_we), .cfg_vl(cfg_vl),
        .cfg_mask_en(cfg_mask_en), .start(start), .op(op), .mask_src(mask_src),
        .mask_dest(mask_dest), .v0_mask(v0_mask), .stall(stall), .flush(flush),
        .busy(busy), .scalar_valid(scalar_valid), .scalar_result(scalar_result),
        .vector_valid(vector_valid), .vector_result(vector_result)
    );

    always #5 CLK = ~CLK;

    // Lengths above VLEN act as VLEN
    function automatic int body_len(input logic [`XLEN-1:0] vl);
        return (vl > `VLEN) ? `VLEN : int'(vl);
    endfunction

    function automatic logic [`VLEN-1:0] active_bits(input int idx);
        logic [`VLEN-1:0] act;
        for (int i = 0; i < `VLEN; i++) begin
            act[i] = src_list[idx][i] && (i < body_len(vl_list[idx])) &&
                     (!en_list[idx] || v0_list[idx][i]);
        end
        return act;
    endfunction

    function automatic int count_ones(input logic [`VLEN-1:0] act);
        int n;
        n = 0;
        for (int i = 0; i < `VLEN; i++) begin
            n = n + int'(act[i]);
        end
        return n;
    endfunction

    // All ones when no bit is set
    function automatic logic [`XLEN-1:0] first_index(input logic [`VLEN-1:0] act);
        logic [`XLEN-1:0] first;
        first = '1;
        for (int i = `VLEN - 1; i >= 0; i--) begin
            if (act[i]) begin
                first = 32'(i);
            end
        end
        return first;
    endfunction

    function automatic logic [`VLEN-1:0] set_mask(input vmaskop_t kind, input int idx);
        logic [`VLEN-1:0] res;
        logic [`XLEN-1:0] first;
        logic             body;
        first = first_index(active_bits(idx));
        for (int i = 0; i < `VLEN; i++) begin
            body = (i < body_len(vl_list[idx])) && (!en_list[idx] || v0_list[idx][i]);
            if (!body) begin
                res[i] = dest_list[idx][i];
            end else if (first == '1) begin
                res[i] = (kind != VMSK_SOF);
            end else begin
                case (kind)
                    VMSK_SBF: res[i] = (i < first);
                    VMSK_SIF: res[i] = (i <= first);
                    default:  res[i] = (i == first);
                endcase
            end
        end
        return res;
    endfunction

    // Element j of viota is the count of active bits below j
    // Element j of vid is j itself
    function automatic logic [`VLEN-1:0] uop_elements(input vmaskop_t kind,
                                                      input logic [`VLEN-1:0] act,
                                                      input int uop);
        logic [`VLEN-1:0] res;
        int               run;
        int               j;
        run = 0;
        for (int i = 0; i < uop * `ELEMS_PER_UOP; i++) begin
            run = run + int'(act[i]);
        end
        for (int k = 0; k < `ELEMS_PER_UOP; k++) begin
            j = uop * `ELEMS_PER_UOP + k;
            res[k*`XLEN +: `XLEN] = (kind == VMSK_IDX) ? 32'(j) : 32'(run);
            run = run + int'(act[j]);
        end
        return res;
    endfunction

    task automatic check_value(input string what, input logic [`VLEN-1:0] got,
                               input logic [`VLEN-1:0] exp);
        checks++;
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic read_vectors();
        int               fd;
        int               n;
        string            line;
        logic [`XLEN-1:0] f_op;
        logic [`XLEN-1:0] f_vl;
        logic [`XLEN-1:0] f_en;
        logic [`VLEN-1:0] f_src;
        logic [`VLEN-1:0] f_dest;
        logic [`VLEN-1:0] f_v0;
        num_vecs = 0;
        fd = $fopen("verif/vmask_vectors.txt", "r");
        if (fd == 0) begin
            setup_errors++;
            $display("Could not open the vector file verif/vmask_vectors.txt");
            return;
        end
        while (!$feof(fd) && num_vecs < MAX_VECS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 1) == "//") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_vl, f_en, f_src, f_dest, f_v0);
            if (n != 6) begin
                setup_errors++;
                $display("Vector line could not be parsed: %s", line);
                continue;
            end
            op_list[num_vecs]   = vmaskop_t'(f_op[2:0]);
            vl_list[num_vecs]   = f_vl;
            en_list[num_vecs]   = f_en[0];
            src_list[num_vecs]  = f_src;
            dest_list[num_vecs] = f_dest;
            v0_list[num_vecs]   = f_v0;
            num_vecs++;
        end
        $fclose(fd);
        if (num_vecs == 0) begin
            setup_errors++;
            $display("The vector file holds no usable lines");
        end
    endtask

    // Config write, then start on the following edge
    task automatic load_operands(input int idx);
        @(posedge CLK);
        cfg_we      <= 1'b1;
        cfg_vl      <= vl_list[idx];
        cfg_mask_en <= en_list[idx];
        stall       <= 1'b0;
        @(posedge CLK);
        cfg_we    <= 1'b0;
        start     <= 1'b1;
        op        <= op_list[idx];
        mask_src  <= src_list[idx];
        mask_dest <= dest_list[idx];
        v0_mask   <= v0_list[idx];
    endtask

    // Drops start, then tries a config write that busy must block
    task automatic write_cfg_while_busy(input int cyc, input int idx);
        if (cyc == 0) begin
            start       <= 1'b0;
            cfg_we      <= 1'b1;
            cfg_vl      <= 32'd1;
            cfg_mask_en <= !en_list[idx];
        end else if (cyc == 1) begin
            cfg_we <= 1'b0;
        end
    endtask

    task automatic wait_result(input int idx, input logic want_vec, output int lat);
        int cyc;
        lat = -1;
        cyc = 0;
        while (lat < 0 && cyc < WALK_LIMIT) begin
            @(negedge CLK);
            if (want_vec ? vector_valid : scalar_valid) begin
                lat = cyc;
            end else begin
                @(posedge CLK);
                write_cfg_while_busy(cyc, idx);
                cyc++;
            end
        end
        if (lat < 0) begin
            timeouts++;
            $display("Timeout: vector %0d gave no result within %0d cycles", idx, WALK_LIMIT);
        end
    endtask

    // Random stall cycles between micro-ops
    task automatic collect_uops(input int idx, input vmaskop_t kind);
        logic [`VLEN-1:0] act;
        int               cyc;
        int               pulses;
        int               first_cyc;
        act       = active_bits(idx);
        cyc       = 0;
        pulses    = 0;
        first_cyc = -1;
        while (pulses < `NUM_UOPS && cyc < VEC_LIMIT) begin
            @(negedge CLK);
            if (vector_valid) begin
                if (first_cyc < 0) begin
                    first_cyc = cyc;
                end
                check_value($sformatf("vector %0d uop %0d", idx, pulses), vector_result,
                            uop_elements(kind, act, pulses));
                pulses++;
            end
            if (pulses < `NUM_UOPS) begin
                @(posedge CLK);
                write_cfg_while_busy(cyc, idx);
                stall <= ($urandom_range(3) == 0);
                cyc++;
            end
        end
        if (pulses < `NUM_UOPS) begin
            timeouts++;
            $display("Timeout: vector %0d gave only %0d of %0d micro-op results",
                     idx, pulses, `NUM_UOPS);
        end else begin
            check_value($sformatf("vector %0d first uop latency", idx), first_cyc, 1);
            check_value($sformatf("vector %0d busy at last uop", idx), busy, 0);
        end
    endtask

    task automatic wait_idle(input int idx);
        int cyc;
        cyc = 0;
        while (busy && cyc < IDLE_LIMIT) begin
            @(negedge CLK);
            cyc++;
        end
        if (busy) begin
            timeouts++;
            $display("Timeout: busy stayed high after vector %0d", idx);
        end
    endtask

    task automatic run_instr(input int idx);
        vmaskop_t         kind;
        logic [`VLEN-1:0] act;
        logic             want_vec;
        int               lat;
        kind     = op_list[idx];
        act      = active_bits(idx);
        want_vec = (kind inside {VMSK_SBF, VMSK_SIF, VMSK_SOF});
        load_operands(idx);
        if (kind inside {VMSK_ITA, VMSK_IDX}) begin
            collect_uops(idx, kind);
        end else begin
            wait_result(idx, want_vec, lat);
            if (lat >= 0) begin
                check_value($sformatf("vector %0d latency", idx), lat, want_vec ? 5 : 4);
                check_value($sformatf("vector %0d busy at result", idx), busy, 0);
                if (kind == VMSK_CNT) begin
                    check_value($sformatf("vector %0d vcpop", idx), scalar_result,
                                count_ones(act));
                end else if (kind == VMSK_FST) begin
                    check_value($sformatf("vector %0d vfirst", idx), scalar_result,
                                first_index(act));
                end else begin
                    check_value($sformatf("vector %0d set mask", idx), vector_result,
                                set_mask(kind, idx));
                end
            end
        end
        wait_idle(idx);
        // Saturated settings survive the write made while busy
        check_value($sformatf("vector %0d vl setting", idx), DUT.vl, body_len(vl_list[idx]));
        check_value($sformatf("vector %0d mask_en setting", idx), DUT.mask_en, en_list[idx]);
    endtask

    // Flush two cycles into the instruction and expect no result afterwards
    task automatic flush_midway(input int idx);
        load_operands(idx);
        @(posedge CLK);
        start <= 1'b0;
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        @(negedge CLK);
        check_value($sformatf("vector %0d busy after flush", idx), busy, 0);
        for (int i = 0; i < 8; i++) begin
            check_value($sformatf("vector %0d valid after flush", idx),
                        {scalar_valid, vector_valid}, 0);
            @(negedge CLK);
        end
    endtask

    initial begin
        void'($urandom(32'h8d4f));
        CLK          = 1'b0;
        nRST         = 1'b0;
        cfg_we       = 1'b0;
        cfg_vl       = '0;
        cfg_mask_en  = 1'b0;
        start        = 1'b0;
        op           = VMSK_NONE;
        mask_src     = '0;
        mask_dest    = '0;
        v0_mask      = '0;
        stall        = 1'b0;
        flush        = 1'b0;
        checks       = 0;
        mismatches   = 0;
        timeouts     = 0;
        setup_errors = 0;
        read_vectors();

        repeat (4) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_value("outputs after reset", {busy, scalar_valid, vector_valid}, 0);
        check_value("vl after reset", DUT.vl, 0);
        check_value("mask_en after reset", DUT.mask_en, 0);

        for (int i = 0; i < num_vecs; i++) begin
            run_instr(i);
        end
        if (num_vecs > 0) begin
            flush_midway(0);
            run_instr(0);
            flush_midway(num_vecs - 1);
            run_instr(num_vecs - 1);
        end

        $display("Checks %0d, mismatches %0d, timeouts %0d, setup errors %0d",
                 checks, mismatches, timeouts, setup_errors);
        if (mismatches == 0 && timeouts == 0 && setup_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* verif/vmask_vectors.txt */
// op vl mask_en mask_src mask_dest v0_mask, all hex
// op: 1 vcpop, 2 vfirst, 3 vmsbf, 4 vmsif, 5 vmsof, 6 viota, 7 vid
1 80 0 f0f0f0f0a5a5a5a5123456789abcdef0 00000000000000000000000000000000 ffffffffffffffffffffffffffffffff
1 45 1 ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 5555555500ff00ffdeadbeef0f0f0f0f
1 300 0 8000000100000000c000000300000001 00000000000000000000000000000000 00000000000000000000000000000000
2 80 0 00000000000000000000000000001000 00000000000000000000000000000000 00000000000000000000000000000000
2 80 0 00000000000000000000400000000000 00000000000000000000000000000000 00000000000000000000000000000000
2 80 1 00000000000000200001000000000001 00000000000000000000000000000000 ffffffffffffffff0000000000000000
2 90 0 80000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000
2 10 0 000000000000000000000000ffff0000 00000000000000000000000000000000 00000000000000000000000000000000
3 64 1 00000000000000000010000000800000 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 ffffffffffffffffffffffffff00ffff
4 80 0 0000000000000000000000000000f000 3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c 00000000000000000000000000000000
5 50 1 0000ffff0000ffff0000ffff0000ff00 c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3c3 ffffffff00ffffffffffffffffff0fff
3 70 0 00000000000000000000000000000000 0123456789abcdef0123456789abcdef 00000000000000000000000000000000
5 200 0 00000000000000000000000000000000 fedcba9876543210fedcba9876543210 00000000000000000000000000000000
6 80 1 f0f0f0f0a5a5a5a5123456789abcdef0 00000000000000000000000000000000 ff00ff00ff00ff00ffffffff0000ffff
7 200 0 00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000
6 3c 0 deadbeefcafef00d0123456789abcdef 00000000000000000000000000000000 00000000000000000000000000000000

/* tb.f */
+incdir+source
source/vmask_pkg.sv
source/vmask_cfg_regs.sv
source/vmask_seq.sv
source/vmask_calc.sv
source/vmask_result_latch.sv
source/vmask_unit.sv
verif/vmask_unit_props.sv
verif/vmask_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vmask_unit_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No pass report in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
